/* logic/uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

//////////////////////////////////////////////////
// Frame format
//////////////////////////////////////////////////

// Data bits per frame, sent LSB first
`define UART_DATA_BITS 8

//////////////////////////////////////////////////
// Receive FIFO
//////////////////////////////////////////////////

// Address width, 2**4 = 16 entries
`define UART_FIFO_AW 4

//////////////////////////////////////////////////
// Bit timing
//////////////////////////////////////////////////

`define UART_OVERSAMPLE 16 // Sample ticks per bit
`define UART_DIVISOR 2     // Clocks per sample tick, 32 clocks per bit

`endif

/* logic/uartPkg.sv */
`default_nettype none

`include "uart_settings.svh"

// Receiver side types
package uartPkg;

        // Frame FSM, one state per field of the frame
        typedef enum logic [2:0] {
                idle   = 3'd0, // Line idle, waiting for a falling edge
                start  = 3'd1, // Start bit, checked at its middle
                data   = 3'd2, // Data bits, LSB first
                parity = 3'd3, // Optional even parity bit
                stop   = 3'd4  // Stop bit, entry pushed here
        } rxState;

        // One FIFO word, flags above the byte
        typedef struct packed {
                logic                       parityErr; // Parity mismatch
                logic                       frameErr;  // Stop bit sampled low
                logic [`UART_DATA_BITS-1:0] dataByte;
        } fifoEntry;

endpackage

`default_nettype wire

/* logic/busPkg.sv */
`default_nettype none

`include "uart_settings.svh"

// Host register map and the 16-bit read word
package busPkg;

        typedef enum logic [1:0] {
                regData    = 2'd0, // Read pops the FIFO
                regStatus  = 2'd1, // Read only
                regControl = 2'd2  // Read and write
        } regAddr;

        // Data register layout
        typedef struct packed {
                logic [12-`UART_DATA_BITS:0] pad;
                logic                        valid;     // Head was present
                logic                        parityErr;
                logic                        frameErr;
                logic [`UART_DATA_BITS-1:0]  dataByte;
        } dataView;

        // Status layout, control bits share the same positions
        typedef struct packed {
                logic [10:0] pad;
                logic        bistMode;
                logic        parityEn;
                logic        overflow;
                logic        halfFull;
                logic        empty;
        } statusView;

        // Same bus word, decoded by address
        typedef union packed {
                dataView   data;
                statusView status;
        } readWord;

endpackage

`default_nettype wire

/* logic/rxBitTimer.sv */
`default_nettype none

`include "uart_settings.svh"

// Oversample divider and bit phase counter
module rxBitTimer (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic timerStart, // Realign on the start edge
        output logic midBit,     // Middle of the bit
        output logic bitEnd      // Last tick of the bit
);

        localparam int DivW   = ($clog2(`UART_DIVISOR) > 0) ? $clog2(`UART_DIVISOR) : 1;
        localparam int PhaseW = $clog2(`UART_OVERSAMPLE);
        localparam logic [DivW-1:0]   DivLast   = DivW'(`UART_DIVISOR - 1);
        localparam logic [PhaseW-1:0] PhaseMid  = PhaseW'(`UART_OVERSAMPLE / 2 - 1);
        localparam logic [PhaseW-1:0] PhaseLast = PhaseW'(`UART_OVERSAMPLE - 1);

        logic [DivW-1:0]   divCnt; // Clocks within a tick
        logic [PhaseW-1:0] phase;  // Ticks within a bit
        logic              tick;

        assign tick = (divCnt == DivLast); // One clock per sample tick

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        divCnt <= '0;
                        phase  <= '0;
                        midBit <= 1'b0;
                        bitEnd <= 1'b0;
                end else if (timerStart) begin // Tick 0 on the start edge
                        divCnt <= '0;
                        phase  <= '0;
                        midBit <= 1'b0;
                        bitEnd <= 1'b0;
                end else begin
                        divCnt <= tick ? '0 : divCnt + 1'b1;
                        if (tick) begin
                                phase <= (phase == PhaseLast) ? '0 : phase + 1'b1;
                        end
                        midBit <= tick && (phase == PhaseMid);  // Single cycle pulses
                        bitEnd <= tick && (phase == PhaseLast);
                end
        end

endmodule

`default_nettype wire

/* logic/rxFrameControl.sv */
`default_nettype none

`include "uart_settings.svh"

// Input synchronizer and frame FSM
module rxFrameControl (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic rxd,        // Raw serial line, idle high
        input  logic parityEn,   // Expect a parity bit
        input  logic midBit,
        output logic timerStart,
        output logic sampleBit,  // rxd after two flops
        output logic shiftEn,    // Data or parity sample
        output logic push        // Stop sample, entry complete
);

        localparam int CntW = ($clog2(`UART_DATA_BITS) > 0) ? $clog2(`UART_DATA_BITS) : 1;
        localparam logic [CntW-1:0] LastBit = CntW'(`UART_DATA_BITS - 1);

        logic [1:0]       syncQ;   // Two flop synchronizer
        logic             lastBit; // Previous synchronized sample
        uartPkg::rxState  state;
        logic [CntW-1:0]  bitCnt;  // Data bits taken so far

        assign sampleBit = syncQ[1];

        // Falling edge while idle starts a frame
        assign timerStart = (state == uartPkg::idle) && lastBit && !sampleBit;

        assign shiftEn = midBit && ((state == uartPkg::data) || (state == uartPkg::parity));
        assign push    = midBit && (state == uartPkg::stop);

        //////////////////////////////////////////////////
        // Synchronizer and FSM
        //////////////////////////////////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        syncQ   <= 2'b11; // Line idles high
                        lastBit <= 1'b1;
                        state   <= uartPkg::idle;
                        bitCnt  <= '0;
                end else begin
                        syncQ   <= {syncQ[0], rxd};
                        lastBit <= sampleBit;
                        if (timerStart) begin
                                state <= uartPkg::start;
                        end else if (midBit) begin
                                case (state)
                                        uartPkg::start: begin
                                                bitCnt <= '0;
                                                // High at mid start is a glitch
                                                state <= sampleBit ? uartPkg::idle : uartPkg::data;
                                        end
                                        uartPkg::data: begin
                                                bitCnt <= bitCnt + 1'b1;
                                                if (bitCnt == LastBit) begin
                                                        state <= parityEn ? uartPkg::parity
                                                                          : uartPkg::stop;
                                                end
                                        end
                                        uartPkg::parity: state <= uartPkg::stop;
                                        uartPkg::stop:   state <= uartPkg::idle;
                                        default:         state <= uartPkg::idle; // Idle ignores ticks
                                endcase
                        end
                end
        end

endmodule

`default_nettype wire

/* logic/rxShifter.sv */
`default_nettype none

`include "uart_settings.svh"

// Data shift register and frame checks
module rxShifter (
        input  logic              Data_Rdy,
        input  logic              Pop_Data,
        input  logic              sampleBit,
        input  logic              shiftEn,
        input  logic              parityEn,
        input  logic              push,
        output uartPkg::fifoEntry entry
);

        // One spare bit above the byte for the parity sample
        logic [`UART_DATA_BITS:0] shiftReg;
        logic                     runParity; // XOR of data and parity samples

        // LSB first, new bits enter at the top
        always_ff @(posedge Data_Rdy) begin
                if (shiftEn) begin
                        shiftReg <= {sampleBit, shiftReg[`UART_DATA_BITS:1]};
                end
        end

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        runParity <= 1'b0;
                end else if (push) begin
                        runParity <= 1'b0; // Fresh start for the next frame
                end else if (shiftEn) begin
                        runParity <= runParity ^ sampleBit;
                end
        end

        // Parity sample sits at the top when enabled
        assign entry.dataByte  = parityEn ? shiftReg[`UART_DATA_BITS-1:0]
                                          : shiftReg[`UART_DATA_BITS:1];
        assign entry.parityErr = parityEn && runParity; // Even parity sums to zero
        assign entry.frameErr  = !sampleBit;            // Stop bit, valid during push

endmodule

`default_nettype wire

/* logic/rxFifo.sv */
`default_nettype none

`include "uart_settings.svh"

// 16-entry show-ahead receive FIFO
module rxFifo (
        input  logic              Data_Rdy,
        input  logic              Pop_Data,
        input  logic              push,
        input  logic              pop,
        input  logic              bistMode, // Freezes everything
        input  uartPkg::fifoEntry entry,
        output uartPkg::fifoEntry head,     // Oldest entry, no pop needed
        output logic              empty,
        output logic              halfFull, // At least half the entries used
        output logic              overflow  // Sticky until a pop
);

        localparam int Depth = 2 ** `UART_FIFO_AW;
        localparam logic [`UART_FIFO_AW:0] Half = (`UART_FIFO_AW + 1)'(Depth / 2);

        uartPkg::fifoEntry       mem [Depth];
        logic [`UART_FIFO_AW-1:0] wrPtr;
        logic [`UART_FIFO_AW-1:0] rdPtr;
        logic [`UART_FIFO_AW:0]   count;     // Occupancy, 0 to 16
        logic [`UART_FIFO_AW:0]   nextCount;
        logic                     full;
        logic                     doPush;
        logic                     doPop;
        logic                     dropPush;  // Frame lost to a full FIFO

        assign full     = count[`UART_FIFO_AW];
        assign doPush   = push && !bistMode && !full;
        assign doPop    = pop && !bistMode && (count != '0);
        assign dropPush = push && !bistMode && full;

        always_comb begin
                nextCount = count;
                if (doPush && !doPop) begin
                        nextCount = count + 1'b1;
                end else if (doPop && !doPush) begin
                        nextCount = count - 1'b1;
                end
        end

        assign head = mem[rdPtr]; // Show-ahead read

        always_ff @(posedge Data_Rdy) begin
                if (doPush) begin
                        mem[wrPtr] <= entry;
                end
        end

        //////////////////////////////////////////////////
        // Pointers and flags
        //////////////////////////////////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        wrPtr    <= '0;
                        rdPtr    <= '0;
                        count    <= '0;
                        empty    <= 1'b1;
                        halfFull <= 1'b0;
                        overflow <= 1'b0;
                end else begin
                        if (doPush) wrPtr <= wrPtr + 1'b1;
                        if (doPop)  rdPtr <= rdPtr + 1'b1;
                        count    <= nextCount;
                        empty    <= (nextCount == '0);
                        halfFull <= (nextCount >= Half);
                        if (dropPush) begin
                                overflow <= 1'b1;
                        end else if (doPop) begin
                                overflow <= 1'b0; // Room again
                        end
                end
        end

endmodule

`default_nettype wire

/* logic/wbRegs.sv */
`default_nettype none

// Wishbone classic slave, register map and control bits
module wbRegs (
        input  logic              Data_Rdy,
        input  logic              Pop_Data,
        input  logic              cyc,
        input  logic              stb,
        input  logic              we,
        input  logic [1:0]        adr,
        input  logic [15:0]       datW,
        input  uartPkg::fifoEntry head,
        input  logic              empty,
        input  logic              halfFull,
        input  logic              overflow,
        output logic              ack,
        output busPkg::readWord   datR,
        output logic              pop,      // One cycle, with the ack edge
        output logic              bistMode,
        output logic              parityEn
);

        busPkg::regAddr    sel;
        busPkg::statusView ctrlIn; // Written word, control positions
        busPkg::readWord   rdNext;
        logic              access; // New cycle, ack not yet given

        assign sel    = busPkg::regAddr'(adr);
        assign ctrlIn = datW;
        assign access = cyc && stb && !ack;

        // Non-empty data read outside BIST
        assign pop = access && !we && (sel == busPkg::regData) && !empty && !bistMode;

        always_comb begin
                rdNext = '0;
                case (sel)
                        busPkg::regData: begin
                                if (!empty) begin // Empty FIFO reads as zero
                                        rdNext.data.valid     = 1'b1;
                                        rdNext.data.parityErr = head.parityErr;
                                        rdNext.data.frameErr  = head.frameErr;
                                        rdNext.data.dataByte  = head.dataByte;
                                end
                        end
                        busPkg::regStatus: begin
                                rdNext.status.bistMode = bistMode;
                                rdNext.status.parityEn = parityEn;
                                rdNext.status.overflow = overflow;
                                rdNext.status.halfFull = halfFull;
                                rdNext.status.empty    = empty;
                        end
                        busPkg::regControl: begin
                                rdNext.status.bistMode = bistMode;
                                rdNext.status.parityEn = parityEn;
                        end
                        default: rdNext = '0; // Unmapped
                endcase
        end

        always_ff @(posedge Data_Rdy) begin
                if (access && !we) datR <= rdNext; // Valid with ack
        end

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        ack      <= 1'b0;
                        bistMode <= 1'b0;
                        parityEn <= 1'b0;
                end else begin
                        ack <= access; // Exactly one cycle
                        if (access && we && (sel == busPkg::regControl)) begin
                                bistMode <= ctrlIn.bistMode;
                                parityEn <= ctrlIn.parityEn;
                        end
                end
        end

endmodule

`default_nettype wire

/* logic/uartRx.sv */
`default_nettype none

// UART receive channel top
module uartRx (
        input  logic            Data_Rdy,
        input  logic            Pop_Data,
        input  logic            rxd,
        input  logic            cyc,
        input  logic            stb,
        input  logic            we,
        input  logic [1:0]      adr,
        input  logic [15:0]     datW,
        output logic            ack,
        output busPkg::readWord datR
);

        logic              timerStart;
        logic              midBit;
        logic              bitEnd;    // Bit boundary, visible to bound checks
        logic              sampleBit;
        logic              shiftEn;
        logic              push;
        logic              pop;
        logic              bistMode;
        logic              parityEn;
        logic              empty;
        logic              halfFull;
        logic              overflow;
        uartPkg::fifoEntry entry;
        uartPkg::fifoEntry head;

        rxBitTimer u_bitTimer (
                .Data_Rdy, .Pop_Data, .timerStart, .midBit, .bitEnd
        );

        rxFrameControl u_frameControl (
                .Data_Rdy, .Pop_Data, .rxd, .parityEn, .midBit,
                .timerStart, .sampleBit, .shiftEn, .push
        );

        rxShifter u_shifter (
                .Data_Rdy, .Pop_Data, .sampleBit, .shiftEn, .parityEn, .push, .entry
        );

        rxFifo u_fifo (
                .Data_Rdy, .Pop_Data, .push, .pop, .bistMode, .entry,
                .head, .empty, .halfFull, .overflow
        );

        wbRegs u_wbRegs (
                .Data_Rdy, .Pop_Data, .cyc, .stb, .we, .adr, .datW,
                .head, .empty, .halfFull, .overflow,
                .ack, .datR, .pop, .bistMode, .parityEn
        );

endmodule

`default_nettype wire

/* test/uartRx_checker.sv */
`default_nettype none

`include "uart_settings.svh"

// Bus, bit timing and FIFO push rules, bound into the receiver top
module uartRx_checker (
        input logic            Data_Rdy,
        input logic            Pop_Data,
        input logic            cyc,
        input logic            stb,
        input logic            ack,
        input logic            midBit,
        input logic            bitEnd,
        input logic            push,
        input logic            bistMode,
        input logic            empty,
        input uartPkg::rxState state
);
        timeunit 1ns;
        timeprecision 100ps;

        // Clocks from the middle sample to the last tick of a bit
        localparam int HalfBit = (`UART_OVERSAMPLE / 2) * `UART_DIVISOR;

        // Slave answers only inside a cycle
        ackInCycle: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                ack |-> (cyc && stb))
                else $error("ack seen without cyc and stb");

        // Inside a frame the bit boundary trails the middle sample by half a bit
        bitHalfPeriod: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                $past(midBit && (state != uartPkg::idle), HalfBit) |-> bitEnd)
                else $error("bitEnd not half a bit after midBit");

        // Stop sample lands an entry at head on the next clock
        pushLands: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                (push && !bistMode) |=> !empty)
                else $error("FIFO still empty after a push");

endmodule

bind uartRx uartRx_checker u_checker (
        .Data_Rdy (Data_Rdy),
        .Pop_Data (Pop_Data),
        .cyc      (cyc),
        .stb      (stb),
        .ack      (ack),
        .midBit   (midBit),
        .bitEnd   (bitEnd),
        .push     (push),
        .bistMode (bistMode),
        .empty    (empty),
        .state    (u_frameControl.state)
);

`default_nettype wire

/* test/uartRx_tb.sv */
`default_nettype none

`include "uart_settings.svh"

module uartRx_tb;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int ClkPeriod = 4;
        localparam int BitClocks = `UART_OVERSAMPLE * `UART_DIVISOR; // Clocks per serial bit
        localparam int MaxPat    = 64;
        localparam int MaxPolls  = 50;  // Status reads allowed per frame

        logic            Data_Rdy;
        logic            Pop_Data;
        logic            rxd;
        logic            cyc;
        logic            stb;
        logic            we;
        logic [1:0]      adr;
        logic [15:0]     datW;
        logic            ack;
        busPkg::readWord datR;

        logic [43:0] pat [MaxPat]; // op ctrl flags count byte expect
        int          nPat;
        integer      seed;
        logic        loaded;

        uartRx u_uartRx (
                .Data_Rdy, .Pop_Data, .rxd, .cyc, .stb, .we, .adr, .datW, .ack, .datR
        );

        initial begin
                Data_Rdy = 1'b0;
                forever #(ClkPeriod / 2) Data_Rdy = ~Data_Rdy;
        end

        //////////////////////////////////////////////////
        // Error reporting and compares
        //////////////////////////////////////////////////

        task automatic stopOnError(input string why);
                $display("%s", why);
                $display("RESULT: FAIL");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic checkData(input busPkg::dataView got, input busPkg::dataView exp);
                if (got !== exp) begin
                        stopOnError($sformatf("FAIL t=%0t datR.data got %h expected %h",
                                              $time, got, exp));
                end
        endtask

        task automatic checkStatus(input busPkg::statusView got, input busPkg::statusView exp);
                if (got !== exp) begin
                        stopOnError($sformatf("FAIL t=%0t datR.status got %h expected %h",
                                              $time, got, exp));
                end
        endtask

        task automatic checkAck(input logic got, input logic exp);
                if (got !== exp) begin
                        stopOnError($sformatf("FAIL t=%0t ack got %b expected %b",
                                              $time, got, exp));
                end
        endtask

        //////////////////////////////////////////////////
        // Bus and serial drivers
        //////////////////////////////////////////////////

        // Entered on a falling edge, leaves on one
        task automatic busAccess(input logic write, input busPkg::regAddr addr,
                                 input logic [15:0] wdata, output busPkg::readWord rdata);
                cyc  = 1'b1;
                stb  = 1'b1;
                we   = write;
                adr  = addr;
                datW = wdata;
                @(negedge Data_Rdy);
                checkAck(ack, 1'b1); // One clock after stb
                rdata = datR;
                @(negedge Data_Rdy); // Held through the ack edge
                cyc = 1'b0;
                stb = 1'b0;
                we  = 1'b0;
                checkAck(ack, 1'b0); // Single cycle ack
        endtask

        task automatic writeControl(input logic [3:0] ctrl);
                busPkg::statusView w;
                busPkg::readWord   unused;
                w          = '0;
                w.bistMode = ctrl[1];
                w.parityEn = ctrl[0];
                busAccess(1'b1, busPkg::regControl, w, unused);
        endtask

        task automatic readData(output busPkg::readWord w);
                busAccess(1'b0, busPkg::regData, 16'h0000, w);
        endtask

        task automatic readStatus(output busPkg::readWord w);
                busAccess(1'b0, busPkg::regStatus, 16'h0000, w);
        endtask

        task automatic sendFrame(input logic [7:0] b, input logic parOn,
                                 input logic badPar, input logic lowStop);
                int gap;
                rxd = 1'b0; // Start bit
                repeat (BitClocks) @(negedge Data_Rdy);
                for (int i = 0; i < `UART_DATA_BITS; i++) begin
                        rxd = b[i]; // LSB first
                        repeat (BitClocks) @(negedge Data_Rdy);
                end
                if (parOn) begin
                        rxd = (^b) ^ badPar; // Even parity, optionally flipped
                        repeat (BitClocks) @(negedge Data_Rdy);
                end
                rxd = !lowStop;
                repeat (BitClocks) @(negedge Data_Rdy);
                rxd = 1'b1;
                gap = 4 + ($unsigned($random(seed)) % 16); // Idle gap, never zero
                repeat (gap) @(negedge Data_Rdy);
        endtask

        // Poll until the entry lands in the FIFO
        task automatic awaitFrame();
                busPkg::readWord s;
                int              polls;
                polls = 0;
                readStatus(s);
                while (s.status.empty && (polls < MaxPolls)) begin
                        readStatus(s);
                        polls++;
                end
                if (s.status.empty) begin
                        stopOnError("a frame was sent but the FIFO never showed an entry");
                end
        endtask

        //////////////////////////////////////////////////
        // Pattern player
        //////////////////////////////////////////////////

        task automatic playPattern(input logic [43:0] p);
                logic [3:0]      op;
                logic [3:0]      ctrl;
                logic [3:0]      flags;
                logic [7:0]      cnt;
                logic [7:0]      b;
                busPkg::readWord exp;
                busPkg::readWord got;
                op    = p[43:40];
                ctrl  = p[39:36];
                flags = p[35:32];
                cnt   = p[31:24];
                b     = p[23:16];
                exp   = p[15:0];
                case (op)
                        4'h0: begin // Single frame, read straight back
                                writeControl(ctrl);
                                sendFrame(b, ctrl[0], flags[0], flags[1]);
                                awaitFrame();
                                readData(got);
                                checkData(got.data, exp.data);
                        end
                        4'h1: begin
                                writeControl(ctrl);
                                for (int i = 0; i < cnt; i++) begin
                                        sendFrame(b, ctrl[0], flags[0], flags[1]);
                                        b = b + 1'b1; // Bytes count up
                                end
                        end
                        4'h2: begin
                                readStatus(got);
                                checkStatus(got.status, exp.status);
                        end
                        4'h3: begin
                                for (int i = 0; i < cnt; i++) begin
                                        readData(got);
                                        checkData(got.data, exp.data);
                                        exp.data.dataByte = exp.data.dataByte + 1'b1;
                                end
                        end
                        4'h4: writeControl(ctrl);
                        default: stopOnError($sformatf("pattern has unknown operation %h", op));
                endcase
        endtask

        initial begin
                cyc      = 1'b0;
                stb      = 1'b0;
                we       = 1'b0;
                adr      = 2'b00;
                datW     = 16'h0000;
                rxd      = 1'b1; // Line idle
                Pop_Data = 1'b1;
                loaded   = 1'b0;
                seed     = 32'h6855;
                for (int i = 0; i < MaxPat; i++) begin
                        pat[i] = '1; // Unused lines read as end markers
                end
                $readmemh("test/uartRx_patterns.mem", pat);
                nPat = 0;
                while ((nPat < MaxPat) && (pat[nPat][43:40] != 4'hF)) begin
                        nPat++;
                end
                loaded = 1'b1;
                repeat (8) @(negedge Data_Rdy);
                Pop_Data = 1'b0;
                repeat (2) @(negedge Data_Rdy);
                for (int i = 0; i < nPat; i++) begin
                        playPattern(pat[i]);
                end
                $display("RESULT: PASS");
                $finish;
        end

        // Twice the time of pattern count plus margin, ten bits each
        initial begin
                longint limit;
                wait (loaded);
                limit = longint'(nPat + 20) * 10 * BitClocks * ClkPeriod * 2;
                #(limit);
                stopOnError("watchdog timeout, the tests did not finish in the allowed time");
        end

endmodule

`default_nettype wire

/* test/uartRx_patterns.mem */
// op ctrl flags count byte expect, op 0 send and read, 1 send, 2 status, 3 read, 4 control, F end
// ctrl bit1 bistMode bit0 parityEn, flags bit1 low stop bit0 bad parity
0_0_0_01_A5_04A5
0_1_0_01_3C_043C
0_1_1_01_5A_065A
0_0_1_01_C3_04C3
0_1_2_01_81_0581
0_0_2_01_7E_057E
2_0_0_00_00_0001
1_0_0_01_10_0000
2_0_0_00_00_0000
1_0_0_07_11_0000
2_0_0_00_00_0002
1_0_0_08_18_0000
2_0_0_00_00_0002
1_0_0_01_EE_0000
2_0_0_00_00_0006
3_0_0_01_00_0410
2_0_0_00_00_0002
3_0_0_0F_00_0411
2_0_0_00_00_0001
1_0_0_01_42_0000
1_2_0_01_99_0000
2_0_0_00_00_0010
3_0_0_01_00_0442
3_0_0_01_00_0442
4_0_0_00_00_0000
3_0_0_01_00_0442
3_0_0_01_00_0000
2_0_0_00_00_0001
F_0_0_00_00_0000

/* all.f */
+incdir+logic
logic/uartPkg.sv
logic/busPkg.sv
logic/rxBitTimer.sv
logic/rxFrameControl.sv
logic/rxShifter.sv
logic/rxFifo.sv
logic/wbRegs.sv
logic/uartRx.sv
test/uartRx_checker.sv
test/uartRx_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the receiver testbench; exit status is the result
cd "$(dirname "$0")" \
        && verilator --binary --timing --assert -Wno-fatal -f all.f \
                --top-module uartRx_tb -o uartRx_sim \
        && ./obj_dir/uartRx_sim \
        || exit 1
